//--- uart_periph.f
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_periph.sv
sim/tb_uart_periph.sv

//--- Bender.yml
package:
  name: uart_periph

sources:
  - source/uart_pkg.sv
  - source/uart_fifo.sv
  - source/uart_tx.sv
  - source/uart_rx.sv
  - source/uart_regs.sv
  - source/uart_periph.sv
  - target: simulation
    files:
      - sim/tb_uart_periph.sv

//--- sim/tb_uart_periph.sv
`default_nettype none

module tb_uart_periph;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUS_TIMEOUT = 50;   // cycles per handshake phase
    localparam int POLL_LIMIT  = 4000; // register polls before giving up
    localparam int LOOP_LIMIT  = 2000;

    logic        clk;
    logic        rst_n;
    logic        bus_enable;
    logic        bus_wr;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [3:0]  bus_be;
    logic        bus_ready;
    logic [31:0] bus_rdata;
    logic        bus_err;
    logic        irq;
    logic        rx_pin;
    logic        tx_pin;
    logic        use_driver;
    logic        drv_pin;
    logic [31:0] lcg_state;
    logic [7:0]  exp_q[$]; // bytes still expected on the rx side
    string       test_name;
    int          checks;
    int          errors;
    int          timeouts;

    uart_periph i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_enable (bus_enable),
        .i_wr_en  (bus_wr),
        .i_addr   (bus_addr),
        .i_data   (bus_wdata),
        .i_be     (bus_be),
        .o_ready  (bus_ready),
        .o_data   (bus_rdata),
        .o_bus_err(bus_err),
        .o_irq    (irq),
        .i_rx_pin (rx_pin),
        .o_tx_pin (tx_pin)
    );

    assign rx_pin = use_driver ? drv_pin : tx_pin; // loopback unless driver owns the line

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15); // fold high bits down
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be, output logic [31:0] rdata, output logic err);
        int wait_cnt;
        @(posedge clk);
        bus_enable <= 1'b1;
        bus_wr     <= wr;
        bus_addr   <= addr;
        bus_wdata  <= wdata;
        bus_be     <= be;
        wait_cnt = 0;
        @(negedge clk);
        while (!bus_ready && wait_cnt < BUS_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!bus_ready) begin
            timeouts++;
            $display("%s: no ready for the access to address %h", test_name, addr);
        end
        rdata = bus_rdata;
        err   = bus_err; // only meaningful while enable is high
        @(posedge clk);
        bus_enable <= 1'b0;
        wait_cnt = 0;
        @(negedge clk);
        while (bus_ready && wait_cnt < BUS_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (bus_ready) begin
            timeouts++;
            $display("%s: ready stayed high after enable dropped", test_name);
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b1, addr, wdata, be, rdata, err);
        check_value("write bus_err", 32'd0, {31'd0, err});
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [3:0] be,
                            output logic [31:0] rdata);
        logic err;
        bus_access(1'b0, addr, 32'd0, be, rdata, err);
        check_value("read bus_err", 32'd0, {31'd0, err});
    endtask

    task automatic poll_until_set(input logic [31:0] addr, input int bit_pos,
                                  input string what, output logic [31:0] value);
        int polls;
        polls = 0;
        read_reg(addr, 4'b0001, value);
        while (!value[bit_pos] && polls < POLL_LIMIT) begin
            read_reg(addr, 4'b0001, value);
            polls++;
        end
        if (!value[bit_pos]) begin
            timeouts++;
            $display("%s: gave up waiting for %s", test_name, what);
        end
    endtask

    task automatic check_rx_byte(input logic [31:0] got);
        logic [7:0] expected;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("%s: byte %h arrived but none was sent", test_name, got[7:0]);
        end
        if (exp_q.size() > 0) begin
            expected = exp_q.pop_front();
            check_value("rx byte", {24'd0, expected}, got);
        end
    endtask

    task automatic check_irq(input string what, input logic expected);
        @(negedge clk);
        check_value(what, {31'd0, expected}, {31'd0, irq});
    endtask

    // 8N1 frame on the driver line followed by two idle bits
    task automatic send_frame(input logic [7:0] value, input logic stop_bit, input int bit_cycles);
        logic [9:0] frame;
        frame = {stop_bit, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            drv_pin <= frame[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_pin <= 1'b1;
        repeat (2 * bit_cycles) @(posedge clk);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] status;
        logic [31:0] val;
        logic [15:0] baud;
        logic [1:0]  int_en_sh;
        logic [7:0]  b;
        logic        err;
        logic        full_seen;
        int          sent;
        int          guard;
        int          accepted;

        rst_n      = 1'b0;
        bus_enable = 1'b0;
        bus_wr     = 1'b0;
        bus_addr   = '0;
        bus_wdata  = '0;
        bus_be     = '0;
        use_driver = 1'b1; // line held idle during reset
        drv_pin    = 1'b1;
        lcg_state  = 32'd98971;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        test_name  = "reset";
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("tx pin idle", 32'd1, {31'd0, tx_pin});
        check_value("irq idle", 32'd0, {31'd0, irq});
        check_value("ready idle", 32'd0, {31'd0, bus_ready});
        check_value("bus_err idle", 32'd0, {31'd0, bus_err});
        check_value("rdata after reset", 32'd0, bus_rdata);

        test_name = "register access";
        baud = 16'd15;
        int_en_sh = 2'b00;
        read_reg(uart_pkg::ADDR_BAUD_L, 4'b0011, rd);
        check_value("baud after reset", {16'd0, baud}, rd);
        for (int i = 0; i < 8; i++) begin
            val = lcg_next();
            case (val[29:28])
                2'd0: begin
                    write_reg(uart_pkg::ADDR_BAUD_L, val, 4'b0011); // full 16 bits
                    baud = val[15:0];
                end
                2'd1: begin
                    write_reg(uart_pkg::ADDR_BAUD_L, val, 4'b0001);
                    baud[7:0] = val[7:0];
                end
                default: begin
                    write_reg(uart_pkg::ADDR_BAUD_H, val, 4'b1111);
                    baud[15:8] = val[7:0];
                end
            endcase
            read_reg(uart_pkg::ADDR_BAUD_L, 4'b0011, rd);
            check_value("baud 16 bit", {16'd0, baud}, rd);
            read_reg(uart_pkg::ADDR_BAUD_L, 4'b0001, rd);
            check_value("baud low", {24'd0, baud[7:0]}, rd);
            read_reg(uart_pkg::ADDR_BAUD_H, 4'b0001, rd);
            check_value("baud high", {24'd0, baud[15:8]}, rd);
        end
        for (int i = 0; i < 4; i++) begin
            val = lcg_next();
            write_reg(uart_pkg::ADDR_INT_EN, val, 4'b1111);
            int_en_sh = val[1:0];
            read_reg(uart_pkg::ADDR_INT_EN, 4'b0001, rd);
            check_value("int_en", {30'd0, int_en_sh}, rd);
        end

        test_name = "bus errors";
        bus_access(1'b1, uart_pkg::ADDR_BAUD_L, lcg_next(), 4'b1110, rd, err);
        check_value("lane 0 missing on write", 32'd1, {31'd0, err});
        bus_access(1'b0, uart_pkg::ADDR_INT_EN, 32'd0, 4'b0010, rd, err);
        check_value("lane 0 missing on read", 32'd1, {31'd0, err});
        for (int i = 0; i < 6; i++) begin
            val = lcg_next();
            if (val < 32'h18) begin
                val = val + 32'h18; // above the last register
            end
            bus_access(val[4], val, lcg_next(), 4'b1111, rd, err);
            check_value("unknown address", 32'd1, {31'd0, err});
        end
        read_reg(uart_pkg::ADDR_BAUD_L, 4'b0011, rd);
        check_value("baud kept", {16'd0, baud}, rd);
        read_reg(uart_pkg::ADDR_INT_EN, 4'b0001, rd);
        check_value("int_en kept", {30'd0, int_en_sh}, rd);
        write_reg(uart_pkg::ADDR_INT_EN, 32'd0, 4'b0001);

        test_name = "loopback";
        val = lcg_next();
        baud = 16'd7 + 16'(val % 32'd14);
        write_reg(uart_pkg::ADDR_BAUD_L, {16'd0, baud}, 4'b0011);
        @(posedge clk);
        use_driver <= 1'b0;
        sent = 0;
        guard = 0;
        while ((sent < 20 || exp_q.size() > 0) && guard < LOOP_LIMIT) begin
            read_reg(uart_pkg::ADDR_STATUS, 4'b0001, status);
            if (status[uart_pkg::STAT_RX_READY]) begin
                check_value("frame_err", 32'd0, {31'd0, status[uart_pkg::STAT_FRAME_ERR]});
                read_reg(uart_pkg::ADDR_DATA, 4'b0001, rd);
                check_rx_byte(rd);
            end else if (sent < 20 && !status[uart_pkg::STAT_TX_FULL]) begin
                b = 8'(lcg_next());
                write_reg(uart_pkg::ADDR_DATA, {24'd0, b}, 4'b0001);
                exp_q.push_back(b);
                sent++;
            end
            guard++;
        end
        if (guard >= LOOP_LIMIT) begin
            timeouts++;
            $display("%s: %0d bytes never came back", test_name, exp_q.size());
            exp_q.delete();
        end

        test_name = "framing error";
        @(posedge clk);
        use_driver <= 1'b1;
        b = 8'(lcg_next());
        exp_q.push_back(b);
        send_frame(b, 1'b0, int'(baud) + 1); // stop bit low
        poll_until_set(uart_pkg::ADDR_STATUS, uart_pkg::STAT_RX_READY, "bad frame", status);
        check_value("frame_err set", 32'd1, {31'd0, status[uart_pkg::STAT_FRAME_ERR]});
        read_reg(uart_pkg::ADDR_DATA, 4'b0001, rd);
        check_rx_byte(rd);
        b = 8'(lcg_next());
        exp_q.push_back(b);
        send_frame(b, 1'b1, int'(baud) + 1);
        poll_until_set(uart_pkg::ADDR_STATUS, uart_pkg::STAT_RX_READY, "good frame", status);
        check_value("frame_err clear", 32'd0, {31'd0, status[uart_pkg::STAT_FRAME_ERR]});
        read_reg(uart_pkg::ADDR_DATA, 4'b0001, rd);
        check_rx_byte(rd);
        @(posedge clk);
        use_driver <= 1'b0;

        test_name = "interrupts";
        write_reg(uart_pkg::ADDR_INT_PEND, 32'd3, 4'b0001); // drop leftovers
        write_reg(uart_pkg::ADDR_INT_EN, 32'd3, 4'b0001);
        read_reg(uart_pkg::ADDR_INT_PEND, 4'b0001, rd);
        check_value("pending cleared", 32'd0, rd);
        check_irq("irq with nothing pending", 1'b0);
        b = 8'(lcg_next());
        exp_q.push_back(b);
        write_reg(uart_pkg::ADDR_DATA, {24'd0, b}, 4'b0001);
        poll_until_set(uart_pkg::ADDR_STATUS, uart_pkg::STAT_RX_READY, "rx data", status);
        check_irq("irq on rx ready", 1'b1);
        read_reg(uart_pkg::ADDR_INT_PEND, 4'b0001, rd);
        check_value("rx pending", 32'd1, {31'd0, rd[uart_pkg::INT_RX_READY]});
        poll_until_set(uart_pkg::ADDR_INT_PEND, uart_pkg::INT_TX_EMPTY, "tx empty", rd);
        check_value("both pending", 32'd3, rd);
        read_reg(uart_pkg::ADDR_DATA, 4'b0001, rd);
        check_rx_byte(rd);
        write_reg(uart_pkg::ADDR_INT_PEND, 32'd1, 4'b0001);
        read_reg(uart_pkg::ADDR_INT_PEND, 4'b0001, rd);
        check_value("rx pending cleared", 32'd2, rd);
        check_irq("irq from tx empty", 1'b1);
        write_reg(uart_pkg::ADDR_INT_PEND, 32'd2, 4'b0001);
        read_reg(uart_pkg::ADDR_INT_PEND, 4'b0001, rd);
        check_value("all pending cleared", 32'd0, rd);
        check_irq("irq after clear", 1'b0);
        write_reg(uart_pkg::ADDR_INT_EN, 32'd0, 4'b0001);
        b = 8'(lcg_next());
        exp_q.push_back(b);
        write_reg(uart_pkg::ADDR_DATA, {24'd0, b}, 4'b0001);
        poll_until_set(uart_pkg::ADDR_STATUS, uart_pkg::STAT_RX_READY, "rx data", status);
        poll_until_set(uart_pkg::ADDR_INT_PEND, uart_pkg::INT_TX_EMPTY, "tx empty", rd);
        check_value("masked pending", 32'd3, rd);
        check_irq("irq while masked", 1'b0);
        read_reg(uart_pkg::ADDR_DATA, 4'b0001, rd);
        check_rx_byte(rd);
        write_reg(uart_pkg::ADDR_INT_PEND, 32'd3, 4'b0001);

        test_name = "tx overflow";
        val = lcg_next();
        baud = 16'd150 + 16'(val % 32'd100);
        write_reg(uart_pkg::ADDR_BAUD_L, {16'd0, baud}, 4'b0011);
        accepted = 0;
        full_seen = 1'b0;
        for (int i = 0; i < 10; i++) begin
            read_reg(uart_pkg::ADDR_STATUS, 4'b0001, status);
            b = 8'(lcg_next());
            write_reg(uart_pkg::ADDR_DATA, {24'd0, b}, 4'b0001);
            if (status[uart_pkg::STAT_TX_FULL]) begin
                full_seen = 1'b1; // this byte is dropped
            end else begin
                exp_q.push_back(b);
                accepted++;
            end
        end
        check_value("tx full seen", 32'd1, {31'd0, full_seen});
        check_value("bytes accepted", 32'd9, accepted);
        guard = 0;
        while (exp_q.size() > 0 && guard < 20) begin
            poll_until_set(uart_pkg::ADDR_STATUS, uart_pkg::STAT_RX_READY, "rx data", status);
            read_reg(uart_pkg::ADDR_DATA, 4'b0001, rd);
            check_rx_byte(rd);
            guard++;
        end
        repeat (20 * (int'(baud) + 1)) @(posedge clk); // two frame times
        read_reg(uart_pkg::ADDR_STATUS, 4'b0001, status);
        check_value("no extra byte", 32'd0, {31'd0, status[uart_pkg::STAT_RX_READY]});

        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/uart_periph.sv
`default_nettype none

module uart_periph (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              i_enable,
    input  wire logic                              i_wr_en,
    input  wire logic [uart_pkg::ADDR_WIDTH-1:0]   i_addr,
    input  wire logic [uart_pkg::DATA_WIDTH-1:0]   i_data,
    input  wire logic [uart_pkg::DATA_WIDTH/8-1:0] i_be,
    output logic                                   o_ready,
    output logic [uart_pkg::DATA_WIDTH-1:0]        o_data,
    output logic                                   o_bus_err,
    output logic                                   o_irq,
    input  wire logic                              i_rx_pin,
    output logic                                   o_tx_pin
);

    logic [uart_pkg::BAUD_WIDTH-1:0] baud_div; // shared by both paths
    logic                            tx_push;
    logic [7:0]                      tx_byte;
    logic                            tx_full;
    logic                            tx_empty;
    logic                            rx_pop;
    logic                            rx_valid;
    uart_pkg::rx_entry_t             rx_head;

    uart_regs i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_wr_en   (i_wr_en),
        .i_addr    (i_addr),
        .i_data    (i_data),
        .i_be      (i_be),
        .i_tx_full (tx_full),
        .i_tx_empty(tx_empty),
        .i_rx_head (rx_head),
        .i_rx_valid(rx_valid),
        .o_ready   (o_ready),
        .o_data    (o_data),
        .o_bus_err (o_bus_err),
        .o_irq     (o_irq),
        .o_baud_div(baud_div),
        .o_tx_push (tx_push),
        .o_tx_byte (tx_byte),
        .o_rx_pop  (rx_pop)
    );

    uart_tx i_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_baud_div(baud_div),
        .i_push    (tx_push),
        .i_byte    (tx_byte),
        .o_full    (tx_full),
        .o_empty   (tx_empty),
        .o_tx_pin  (o_tx_pin)
    );

    uart_rx i_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_baud_div(baud_div),
        .i_rx_pin  (i_rx_pin),
        .i_pop     (rx_pop),
        .o_head    (rx_head),
        .o_valid   (rx_valid)
    );

endmodule

`default_nettype wire

//--- source/uart_regs.sv
`default_nettype none

module uart_regs (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              i_enable,
    input  wire logic                              i_wr_en,
    input  wire logic [uart_pkg::ADDR_WIDTH-1:0]   i_addr,
    input  wire logic [uart_pkg::DATA_WIDTH-1:0]   i_data,
    input  wire logic [uart_pkg::DATA_WIDTH/8-1:0] i_be,
    input  wire logic                              i_tx_full,
    input  wire logic                              i_tx_empty,
    input  wire uart_pkg::rx_entry_t               i_rx_head,
    input  wire logic                              i_rx_valid,
    output logic                                   o_ready,
    output logic [uart_pkg::DATA_WIDTH-1:0]        o_data,
    output logic                                   o_bus_err,
    output logic                                   o_irq,
    output logic [uart_pkg::BAUD_WIDTH-1:0]        o_baud_div,
    output logic                                   o_tx_push,
    output logic [7:0]                             o_tx_byte,
    output logic                                   o_rx_pop
);

    localparam int DW = uart_pkg::DATA_WIDTH;

    typedef enum logic {
        ST_ISSUE,
        ST_RETIRE
    } bus_state_t;

    bus_state_t      state;
    logic            err_q;
    logic [1:0]      int_en;
    logic [1:0]      int_pend;
    logic [1:0]      pend_set;
    logic [1:0]      pend_clr;
    logic            rx_valid_prev;
    logic            tx_empty_prev;
    logic            addr_hit;
    logic            issue;
    logic            wr_fire;
    logic            rd_fire;
    logic [DW-1:0]   rd_val;

    // address decode and read data
    always_comb begin
        addr_hit = 1'b1;
        rd_val   = '0;
        case (i_addr)
            uart_pkg::ADDR_BAUD_L: begin
                if (i_be[1]) begin
                    rd_val = {{(DW-16){1'b0}}, o_baud_div};
                end else begin
                    rd_val = {{(DW-8){1'b0}}, o_baud_div[7:0]};
                end
            end
            uart_pkg::ADDR_BAUD_H: rd_val = {{(DW-8){1'b0}}, o_baud_div[15:8]};
            uart_pkg::ADDR_STATUS: begin
                rd_val[uart_pkg::STAT_RX_READY]  = i_rx_valid;
                rd_val[uart_pkg::STAT_TX_FULL]   = i_tx_full;
                rd_val[uart_pkg::STAT_FRAME_ERR] = i_rx_valid && i_rx_head.frame_err;
            end
            uart_pkg::ADDR_DATA: begin
                if (i_rx_valid) begin
                    rd_val = {{(DW-8){1'b0}}, i_rx_head.data}; // empty fifo reads 0
                end
            end
            uart_pkg::ADDR_INT_EN:   rd_val = {{(DW-2){1'b0}}, int_en};
            uart_pkg::ADDR_INT_PEND: rd_val = {{(DW-2){1'b0}}, int_pend};
            default:                 addr_hit = 1'b0;
        endcase
    end

    assign issue   = i_enable && i_be[0] && !o_ready && !err_q && (state == ST_ISSUE);
    assign wr_fire = issue && addr_hit && i_wr_en;
    assign rd_fire = issue && addr_hit && !i_wr_en;

    // pop lines up with capturing the head into o_data
    assign o_rx_pop = rd_fire && (i_addr == uart_pkg::ADDR_DATA) && i_rx_valid;

    assign pend_clr = (wr_fire && i_addr == uart_pkg::ADDR_INT_PEND) ? i_data[1:0] : 2'b00;

    always_comb begin
        pend_set                        = 2'b00;
        pend_set[uart_pkg::INT_RX_READY] = i_rx_valid && !rx_valid_prev;
        pend_set[uart_pkg::INT_TX_EMPTY] = i_tx_empty && !tx_empty_prev;
    end

    assign o_irq     = |(int_en & int_pend);
    assign o_bus_err = i_enable && err_q; // meaningful only during a transfer

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_ISSUE;
            err_q         <= 1'b0;
            o_ready       <= 1'b0;
            o_data        <= '0;
            o_baud_div    <= uart_pkg::BAUD_RESET;
            o_tx_push     <= 1'b0;
            int_en        <= 2'b00;
            int_pend      <= 2'b00;
            rx_valid_prev <= 1'b0;
            tx_empty_prev <= 1'b1; // so reset raises no tx-empty edge
        end else begin
            rx_valid_prev <= i_rx_valid;
            tx_empty_prev <= i_tx_empty;
            int_pend      <= (int_pend & ~pend_clr) | pend_set; // new edge wins over clear
            o_tx_push     <= 1'b0;

            if (!i_enable) begin
                o_ready <= 1'b0; // master idles between commands
                err_q   <= 1'b0;
                state   <= ST_ISSUE;
            end else if (!i_be[0]) begin
                err_q   <= 1'b1; // lane 0 is mandatory
                o_ready <= 1'b1;
            end else if (issue && !addr_hit) begin
                err_q   <= 1'b1;
                o_ready <= 1'b1;
            end else if (wr_fire) begin
                case (i_addr)
                    uart_pkg::ADDR_BAUD_L: begin
                        if (i_be[1]) begin
                            o_baud_div <= i_data[15:0];
                        end else begin
                            o_baud_div[7:0] <= i_data[7:0];
                        end
                    end
                    uart_pkg::ADDR_BAUD_H: o_baud_div[15:8] <= i_data[7:0];
                    uart_pkg::ADDR_DATA: begin
                        o_tx_push <= !i_tx_full; // full fifo drops the byte here
                        o_tx_byte <= i_data[7:0];
                    end
                    uart_pkg::ADDR_INT_EN: int_en <= i_data[1:0];
                    default: ; // status is read only, pending handled above
                endcase
                state <= ST_RETIRE;
            end else if (rd_fire) begin
                o_data <= rd_val;
                state  <= ST_RETIRE;
            end else if (state == ST_RETIRE && !o_ready) begin
                o_ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`default_nettype none

module uart_rx (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic [uart_pkg::BAUD_WIDTH-1:0] i_baud_div,
    input  wire logic                            i_rx_pin,
    input  wire logic                            i_pop,
    output uart_pkg::rx_entry_t                  o_head,
    output logic                                 o_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t                       state;
    logic [1:0]                      sync_q;
    logic                            rx_s;
    logic                            rx_prev;
    logic [uart_pkg::BAUD_WIDTH-1:0] cnt;
    logic [2:0]                      bit_idx;
    logic [7:0]                      shift;
    logic                            fifo_full;
    logic                            fifo_push;
    uart_pkg::rx_entry_t             entry;

    assign rx_s = sync_q[1];

    // entry is built from the live stop sample
    always_comb begin
        entry.data      = shift;
        entry.frame_err = !rx_s;
    end

    // a byte landing on a full fifo is dropped
    assign fifo_push = (state == ST_STOP) && (cnt == '0) && !fifo_full;

    uart_fifo #(
        .payload_t(uart_pkg::rx_entry_t)
    ) i_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_push (fifo_push),
        .i_data (entry),
        .i_pop  (i_pop),
        .o_head (o_head),
        .o_valid(o_valid),
        .o_full (fifo_full),
        .o_empty()
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q  <= 2'b11; // line idles high
            rx_prev <= 1'b1;
            state   <= ST_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            sync_q  <= {sync_q[0], i_rx_pin};
            rx_prev <= rx_s;
            if (state != ST_IDLE && cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                case (state)
                    ST_IDLE: if (rx_prev && !rx_s) begin
                        cnt   <= i_baud_div >> 1; // go to mid start bit
                        state <= ST_START;
                    end
                    ST_START: begin
                        if (!rx_s) begin
                            cnt     <= i_baud_div;
                            bit_idx <= '0;
                            state   <= ST_DATA;
                        end else begin
                            state <= ST_IDLE; // glitch, not a real start
                        end
                    end
                    ST_DATA: begin
                        shift <= {rx_s, shift[7:1]}; // lsb arrives first
                        cnt   <= i_baud_div;
                        if (bit_idx == 3'd7) begin
                            state <= ST_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                    default: state <= ST_IDLE; // stop sampled, entry pushed
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`default_nettype none

module uart_tx (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic [uart_pkg::BAUD_WIDTH-1:0] i_baud_div,
    input  wire logic                            i_push,
    input  wire logic [7:0]                      i_byte,
    output logic                                 o_full,
    output logic                                 o_empty,
    output logic                                 o_tx_pin
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } tx_state_t;

    tx_state_t                     state;
    logic [uart_pkg::BAUD_WIDTH-1:0] cnt;
    logic [2:0]                    bit_idx;
    logic [7:0]                    shift;
    logic [7:0]                    fifo_head;
    logic                          fifo_valid;
    logic                          fifo_empty;
    logic                          fifo_pop;

    uart_fifo #(
        .payload_t(logic [7:0])
    ) i_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_push (i_push),
        .i_data (i_byte),
        .i_pop  (fifo_pop),
        .o_head (fifo_head),
        .o_valid(fifo_valid),
        .o_full (o_full),
        .o_empty(fifo_empty)
    );

    assign fifo_pop = (state == ST_IDLE) && fifo_valid; // take the head as we leave idle
    assign o_empty  = fifo_empty && (state == ST_IDLE);  // nothing queued and line quiet

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            o_tx_pin <= 1'b1;
        end else begin
            if (state != ST_IDLE && cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                case (state)
                    ST_IDLE: if (fifo_valid) begin
                        shift    <= fifo_head;
                        o_tx_pin <= 1'b0; // start bit
                        cnt      <= i_baud_div;
                        state    <= ST_START;
                    end
                    ST_START: begin
                        o_tx_pin <= shift[0]; // lsb first
                        shift    <= shift >> 1;
                        bit_idx  <= '0;
                        cnt      <= i_baud_div;
                        state    <= ST_DATA;
                    end
                    ST_DATA: begin
                        cnt <= i_baud_div;
                        if (bit_idx == 3'd7) begin
                            o_tx_pin <= 1'b1; // stop bit
                            state    <= ST_STOP;
                        end else begin
                            o_tx_pin <= shift[0];
                            shift    <= shift >> 1;
                            bit_idx  <= bit_idx + 1'b1;
                        end
                    end
                    default: state <= ST_IDLE; // stop bit done
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/uart_fifo.sv
`default_nettype none

module uart_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     i_push,
    input  wire payload_t i_data,
    input  wire logic     i_pop,
    output payload_t      o_head,
    output logic          o_valid,
    output logic          o_full,
    output logic          o_empty
);

    localparam int DEPTH = uart_pkg::FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;  // push into a full fifo is lost
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    assign o_head  = mem[rd_ptr]; // first word falls through
    assign o_empty = (count == '0);
    assign o_valid = !o_empty;
    assign o_full  = (count == (PTR_W+1)'(DEPTH));

endmodule

`default_nettype wire

//--- source/uart_pkg.sv
`default_nettype none

package uart_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int BAUD_WIDTH = 16;

    localparam logic [ADDR_WIDTH-1:0] ADDR_BAUD_L   = 32'h00; // low byte, or 16 bits with be[1]
    localparam logic [ADDR_WIDTH-1:0] ADDR_BAUD_H   = 32'h04;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS   = 32'h08; // read only
    localparam logic [ADDR_WIDTH-1:0] ADDR_DATA     = 32'h0C; // write pushes tx, read pops rx
    localparam logic [ADDR_WIDTH-1:0] ADDR_INT_EN   = 32'h10;
    localparam logic [ADDR_WIDTH-1:0] ADDR_INT_PEND = 32'h14; // write 1 to clear

    localparam int INT_RX_READY = 0;
    localparam int INT_TX_EMPTY = 1;

    localparam int STAT_RX_READY  = 0;
    localparam int STAT_TX_FULL   = 1;
    localparam int STAT_FRAME_ERR = 2;

    localparam int FIFO_DEPTH = 8;
    localparam logic [BAUD_WIDTH-1:0] BAUD_RESET = 16'd15; // 16 clocks per bit

    typedef struct packed {
        logic [7:0] data;
        logic       frame_err; // stop bit sampled low
    } rx_entry_t;

endpackage

`default_nettype wire
